// File: compile.f
+incdir+rtl
rtl/readout_pkg.sv
rtl/group_if.sv
rtl/grant_if.sv
rtl/pixel_level.sv
rtl/pixel_groups.sv
rtl/group_arbiter.sv
rtl/timestamp_counter.sv
rtl/readout_ctrl.sv
rtl/pixel_readout_top.sv
bench/tb_pixel_readout.sv

// File: bench/tb_pixel_readout.sv
`timescale 1ns/100ps
`include "readout_params.svh"

module tb_pixel_readout;

   localparam int NPIX = `PIX_ROWS * `PIX_COLS;

   logic                                clk_i;
   logic                                rst_n_i;
   logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] pix_req_i;
   logic                                credit_i;
   logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] pix_ack_o;
   logic                                evt_valid_o;
   logic [15:0]                         evt_data_o;

   logic [NPIX-1:0] req_set;       // new requests, applied by the driver
   logic [NPIX-1:0] ack_mid;
   logic [1:0]      credit_sched;  // credit return delay line
   int              release_cnt;
   int              owed;
   bit              credit_auto;
   int              cyc_mirror;
   int              last_cyc;
   logic [15:0]     words[$];
   logic [NPIX-1:0] acks[$];
   int              order[$];      // pixel index per pixel word
   int              rep_cnt[NPIX];
   int              tot_words;
   int              errors;
   bit              timed_out;
   string           cur_test;
   integer          seed;
   logic [15:0]     mon_word;
   int              mon_idx;

   pixel_readout_top pixel_readout_top_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .pix_req_i   (pix_req_i),
      .credit_i    (credit_i),
      .pix_ack_o   (pix_ack_o),
      .evt_valid_o (evt_valid_o),
      .evt_data_o  (evt_data_o)
   );

   always #2 clk_i = ~clk_i;

   function automatic int pix_index(input int x, input int y);
      return y * `PIX_COLS + x;
   endfunction

   function automatic int group_of(input int idx);
      return (idx / `PIX_COLS / `GRP_ROWS) * (`PIX_COLS / `GRP_COLS)
             + (idx % `PIX_COLS) / `GRP_COLS;
   endfunction

   task automatic value_error(input string what, input logic [63:0] exp,
                              input logic [63:0] act);
      errors++;
      $display("error %s: %s expected %0h actual %0h", cur_test, what, exp, act);
   endtask

   task automatic plain_error(input string msg);
      errors++;
      $display("%s: %s", cur_test, msg);
   endtask

   // timestamp mirror starts at 0 in the first cycle out of reset
   always @(posedge clk_i) begin
      if (!rst_n_i) cyc_mirror <= 0;
      else cyc_mirror <= cyc_mirror + 1;
   end

   // pixel and credit models
   always @(posedge clk_i) begin
      #0.5;
      pix_req_i = (pix_req_i & ~ack_mid) | req_set;  // acked pixels drop
      req_set   = '0;
      if (credit_sched[0]) begin
         credit_i = 1'b1;
      end else if (release_cnt > 0) begin
         credit_i = 1'b1;
         release_cnt--;
      end else begin
         credit_i = 1'b0;
      end
      credit_sched = credit_sched >> 1;
   end

   // output monitor samples at mid cycle
   always @(negedge clk_i) begin
      ack_mid = rst_n_i ? pix_ack_o : '0;
      if (rst_n_i && evt_valid_o) begin
         mon_word = evt_data_o;
         words.push_back(mon_word);
         acks.push_back(pix_ack_o);
         tot_words++;
         if (credit_auto) credit_sched[1] = 1'b1;
         else owed++;
         if (mon_word[15] == 1'b0) begin
            mon_idx = pix_index(mon_word[14:12], mon_word[11:9]);
            order.push_back(mon_idx);
            rep_cnt[mon_idx]++;
            if (pix_ack_o !== (NPIX'(1) << mon_idx)) begin
               value_error("pix_ack_o", NPIX'(1) << mon_idx, pix_ack_o);
            end
            if (mon_word[8:0] !== last_cyc[8:0]) begin
               value_error("ts_low", last_cyc[8:0], mon_word[8:0]);
            end
         end else begin
            if (pix_ack_o !== '0) value_error("ack with marker", 0, pix_ack_o);
            if (mon_word[14:0] !== 15'(last_cyc >> `TS_LOW_W)) begin
               value_error("ts_high", last_cyc >> `TS_LOW_W, mon_word[14:0]);
            end
         end
      end else if (rst_n_i && pix_ack_o !== '0) begin
         plain_error("acknowledge seen without an event word");
      end
      last_cyc = cyc_mirror;
   end

   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic idle(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic clear_records();
      words.delete();
      acks.delete();
      order.delete();
      foreach (rep_cnt[i]) rep_cnt[i] = 0;
   endtask

   task automatic raise_pixels(input logic [NPIX-1:0] mask);
      req_set = mask;
      next_cycle();
   endtask

   task automatic wait_pixels(input int n, input int limit);
      int cnt;
      cnt = 0;
      while (order.size() < n && cnt < limit && !timed_out) begin
         next_cycle();
         cnt++;
      end
      if (order.size() < n && !timed_out) begin
         timed_out = 1'b1;
         $display("timeout in %s: only %0d of %0d pixel words after %0d cycles",
                  cur_test, order.size(), n, limit);
      end
   endtask

   task automatic wait_cycle(input int target, input int limit);
      int cnt;
      cnt = 0;
      while (cyc_mirror < target && cnt < limit) begin
         next_cycle();
         cnt++;
      end
      if (cyc_mirror < target) begin
         timed_out = 1'b1;
         $display("timeout in %s: cycle %0d never reached", cur_test, target);
      end
   endtask

   task automatic check_each_once(input logic [NPIX-1:0] mask);
      for (int i = 0; i < NPIX; i++) begin
         if (rep_cnt[i] != int'(mask[i])) begin
            value_error($sformatf("reports of pixel %0d", i), mask[i], rep_cnt[i]);
         end
      end
   endtask

   task automatic reset_quiet();
      cur_test = "reset";
      for (int i = 0; i < 20; i++) begin
         if (evt_valid_o !== 1'b0) value_error("evt_valid_o", 0, evt_valid_o);
         if (pix_ack_o !== '0) value_error("pix_ack_o", 0, pix_ack_o);
         next_cycle();
      end
   endtask

   task automatic single_pixel();
      cur_test = "single pixel";
      clear_records();
      raise_pixels(NPIX'(1) << pix_index(5, 2));
      wait_pixels(1, 40);
      idle(8);
      if (words.size() != 1) value_error("word count", 1, words.size());
      if (words.size() > 0) begin
         if (words[0][15] !== 1'b0) value_error("kind", 0, words[0][15]);
         if (words[0][14:12] !== 3'd5) value_error("x", 5, words[0][14:12]);
         if (words[0][11:9] !== 3'd2) value_error("y", 2, words[0][11:9]);
      end
   endtask

   task automatic group_lock();
      logic [NPIX-1:0] mask;
      int              switches;
      cur_test = "group lock";
      clear_records();
      mask = '0;
      mask[pix_index(0, 0)] = 1'b1;  // group 0
      mask[pix_index(1, 0)] = 1'b1;
      mask[pix_index(1, 1)] = 1'b1;
      mask[pix_index(2, 2)] = 1'b1;  // group 5
      mask[pix_index(3, 2)] = 1'b1;
      mask[pix_index(2, 3)] = 1'b1;
      raise_pixels(mask);
      wait_pixels(6, 80);
      idle(8);
      check_each_once(mask);
      switches = 0;
      for (int i = 1; i < order.size(); i++) begin
         if (group_of(order[i]) != group_of(order[i-1])) switches++;
      end
      if (switches != 1) value_error("group switches", 1, switches);
   endtask

   task automatic credit_backpressure();
      logic [NPIX-1:0] mask;
      cur_test = "credit back-pressure";
      clear_records();
      mask = '0;
      mask[pix_index(0, 7)] = 1'b1;
      mask[pix_index(7, 0)] = 1'b1;
      mask[pix_index(4, 4)] = 1'b1;
      mask[pix_index(6, 1)] = 1'b1;
      mask[pix_index(1, 5)] = 1'b1;
      mask[pix_index(3, 3)] = 1'b1;
      credit_auto = 1'b0;
      owed        = 0;
      raise_pixels(mask);
      wait_pixels(`MAX_CREDITS, 60);
      idle(30);
      if (words.size() != `MAX_CREDITS) begin
         value_error("words without credit", `MAX_CREDITS, words.size());
      end
      if ($countones(pix_req_i) != 6 - `MAX_CREDITS) begin
         value_error("pending requests", 6 - `MAX_CREDITS, $countones(pix_req_i));
      end
      credit_auto = 1'b1;
      release_cnt = owed;  // hand back what was held
      owed        = 0;
      wait_pixels(6, 80);
      idle(8);
      check_each_once(mask);
   endtask

   task automatic timestamp_marker();
      int px;
      cur_test = "timestamp marker";
      clear_records();
      px = pix_index(6, 3);
      if (cyc_mirror >= (1 << `TS_LOW_W) - 8) plain_error("run already past the first wrap");
      wait_cycle((1 << `TS_LOW_W) - 1, 700);
      raise_pixels(NPIX'(1) << px);  // requests from the first cycle after the wrap
      wait_pixels(1, 40);
      idle(8);
      if (words.size() != 2) value_error("word count", 2, words.size());
      if (words.size() == 2) begin
         if (words[0][15] !== 1'b1) value_error("first word kind", 1, words[0][15]);
         if (words[0][14:0] !== 15'd1) value_error("marker ts_high", 1, words[0][14:0]);
         if (acks[0] !== '0) value_error("ack with marker", 0, acks[0]);
         if (words[1][15] !== 1'b0) value_error("second word kind", 0, words[1][15]);
         if (order[0] != px) value_error("pixel after marker", px, order[0]);
      end
   endtask

   task automatic random_pattern();
      logic [31:0]     r0;
      logic [31:0]     r1;
      logic [31:0]     r2;
      logic [31:0]     r3;
      logic [NPIX-1:0] mask;
      int              n;
      cur_test = "random pattern";
      for (int round = 0; round < 4 && !timed_out; round++) begin
         clear_records();
         r0   = $random(seed);
         r1   = $random(seed);
         r2   = $random(seed);
         r3   = $random(seed);
         mask = {r0, r1} & {r2, r3};  // about a quarter of the array
         if (mask == '0) mask[0] = 1'b1;
         n = $countones(mask);
         raise_pixels(mask);
         wait_pixels(n, n * 4 + 40);
         idle(8);
         if (order.size() != n) value_error("pixel words", n, order.size());
         check_each_once(mask);
      end
   endtask

   initial begin
      clk_i        = 1'b0;
      rst_n_i      = 1'b0;
      pix_req_i    = '0;
      credit_i     = 1'b0;
      req_set      = '0;
      ack_mid      = '0;
      credit_sched = '0;
      release_cnt  = 0;
      owed         = 0;
      credit_auto  = 1'b1;
      cyc_mirror   = 0;
      last_cyc     = 0;
      tot_words    = 0;
      errors       = 0;
      timed_out    = 1'b0;
      seed         = 32'h125f;
      cur_test     = "reset";
      repeat (4) @(posedge clk_i);
      #0.5;
      rst_n_i = 1'b1;
      #0.5;
      reset_quiet();
      if (!timed_out) single_pixel();
      if (!timed_out) group_lock();
      if (!timed_out) credit_backpressure();
      if (!timed_out) timestamp_marker();
      if (!timed_out) random_pattern();
      $display("errors %0d, timeouts %0d, words seen %0d", errors, timed_out, tot_words);
      if (errors == 0 && !timed_out) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: rtl/pixel_readout_top.sv
`timescale 1ns/100ps
`include "readout_params.svh"

module pixel_readout_top (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] pix_req_i,
   input  logic                                credit_i,
   output logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] pix_ack_o,
   output logic                                evt_valid_o,
   output logic [15:0]                         evt_data_o
);

   logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] gnt_out;
   logic [`TS_LOW_W-1:0]                ts_low;
   logic [`TS_HIGH_W-1:0]               ts_high;
   logic                                marker_pend;
   logic                                marker_taken;

   group_if group_bus ();
   grant_if grant_bus ();

   pixel_groups pixel_groups_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .req_i     (pix_req_i),
      .grp       (group_bus.grp),
      .gnt_out_o (gnt_out)
   );

   group_arbiter group_arbiter_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .grp     (group_bus.arb),
      .gnt     (grant_bus.arb)
   );

   timestamp_counter timestamp_counter_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .marker_taken_i (marker_taken),
      .ts_low_o       (ts_low),
      .ts_high_o      (ts_high),
      .marker_pend_o  (marker_pend)
   );

   readout_ctrl readout_ctrl_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .credit_i       (credit_i),
      .ts_low_i       (ts_low),
      .ts_high_i      (ts_high),
      .marker_pend_i  (marker_pend),
      .gnt            (grant_bus.ctrl),
      .gnt_out_i      (gnt_out),
      .marker_taken_o (marker_taken),
      .evt_valid_o    (evt_valid_o),
      .evt_data_o     (evt_data_o),
      .pix_ack_o      (pix_ack_o)
   );

endmodule

// File: rtl/readout_ctrl.sv
`timescale 1ns/100ps
`include "readout_params.svh"

module readout_ctrl (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic                                credit_i,
   input  logic [`TS_LOW_W-1:0]                ts_low_i,
   input  logic [`TS_HIGH_W-1:0]               ts_high_i,
   input  logic                                marker_pend_i,
   grant_if.ctrl                               gnt,
   input  logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] gnt_out_i,
   output logic                                marker_taken_o,
   output logic                                evt_valid_o,
   output readout_pkg::evt_word_u              evt_data_o,
   output logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] pix_ack_o
);

   localparam logic [1:0] ST_READY = 2'd0;
   localparam logic [1:0] ST_WAIT1 = 2'd1;
   localparam logic [1:0] ST_WAIT2 = 2'd2;
   localparam logic [`CREDIT_W-1:0] CREDIT_INIT = `MAX_CREDITS;

   logic [1:0]           state_q;
   logic [`CREDIT_W-1:0] credit_q;
   logic                 can_fire;
   logic                 pix_fire;
   logic                 emit;

   assign can_fire       = (state_q == ST_READY) && (credit_q != '0);
   assign marker_taken_o = can_fire & marker_pend_i;   // marker goes ahead of pixels
   assign pix_fire       = can_fire & ~marker_pend_i & gnt.active;
   assign gnt.fire       = pix_fire;
   assign emit           = marker_taken_o | pix_fire;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q     <= ST_READY;
         credit_q    <= CREDIT_INIT;
         evt_valid_o <= 1'b0;
         pix_ack_o   <= '0;
      end else begin
         evt_valid_o <= emit;
         pix_ack_o   <= pix_fire ? gnt_out_i : '0;
         case (state_q)
            ST_READY: begin
               if (emit) begin
                  state_q <= ST_WAIT1;
               end
            end
            ST_WAIT1: state_q <= ST_WAIT2;
            default:  state_q <= ST_READY;  // pixel drops its request meanwhile
         endcase
         // word out and credit back in the same cycle cancel
         if (emit && !credit_i) begin
            credit_q <= credit_q - 1'b1;
         end else if (credit_i && !emit) begin
            credit_q <= credit_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (marker_taken_o) begin
         evt_data_o.marker.kind    <= readout_pkg::EVT_KIND_TS;
         evt_data_o.marker.ts_high <= ts_high_i;
      end else if (pix_fire) begin
         evt_data_o.pix.kind   <= readout_pkg::EVT_KIND_PIX;
         evt_data_o.pix.x      <= gnt.x;
         evt_data_o.pix.y      <= gnt.y;
         evt_data_o.pix.ts_low <= ts_low_i;  // time of the fire cycle
      end
   end

endmodule

// File: rtl/timestamp_counter.sv
`timescale 1ns/100ps
`include "readout_params.svh"

module timestamp_counter (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  marker_taken_i,
   output logic [`TS_LOW_W-1:0]  ts_low_o,
   output logic [`TS_HIGH_W-1:0] ts_high_o,
   output logic                  marker_pend_o
);

   logic [`TS_HIGH_W+`TS_LOW_W-1:0] ts_q;
   logic                            wrap;

   assign wrap = &ts_q[`TS_LOW_W-1:0];  // low part is 0 after this edge
   assign {ts_high_o, ts_low_o} = ts_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ts_q          <= '0;
         marker_pend_o <= 1'b0;
      end else begin
         ts_q <= ts_q + 1'b1;
         if (wrap) begin
            marker_pend_o <= 1'b1;
         end else if (marker_taken_i) begin
            marker_pend_o <= 1'b0;
         end
      end
   end

endmodule

// File: rtl/group_arbiter.sv
`timescale 1ns/100ps
`include "readout_params.svh"

module group_arbiter (
   input  logic clk_i,
   input  logic rst_n_i,
   group_if.arb grp,
   grant_if.arb gnt
);

   localparam int GIW = $clog2(`NUM_GRP);
   localparam int GCW = `PIX_AW - `GRP_AW;  // group column index width

   logic [`NUM_GRP-1:0] req_flat;
   logic [`NUM_GRP-1:0] en_flat;
   logic [GIW-1:0]      ptr_q;
   logic [GIW-1:0]      lock_grp_q;
   logic                lock_q;
   logic [GIW-1:0]      pick;
   logic [GIW-1:0]      cand;
   logic                pick_any;
   logic [GIW-1:0]      en_idx;
   logic                en_valid;

   assign req_flat = grp.grp_req;

   // next requesting group after the pointer
   always_comb begin
      pick     = ptr_q;
      pick_any = 1'b0;
      for (int i = 1; i <= `NUM_GRP; i++) begin
         cand = ptr_q + GIW'(i);
         if (!pick_any && req_flat[cand]) begin
            pick     = cand;
            pick_any = 1'b1;
         end
      end
   end

   assign en_idx   = lock_q ? lock_grp_q : pick;
   assign en_valid = lock_q | pick_any;

   always_comb begin
      en_flat         = '0;
      en_flat[en_idx] = en_valid;
   end

   assign grp.grp_en = en_flat;
   assign grp.fire   = gnt.fire;

   assign gnt.active = en_valid & grp.sel_active;
   assign gnt.x      = {en_idx[GCW-1:0], grp.sel_x};    // group column, local column
   assign gnt.y      = {en_idx[GIW-1:GCW], grp.sel_y};

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         lock_q     <= 1'b0;
         lock_grp_q <= '0;
         ptr_q      <= '1;
      end else if (gnt.fire) begin
         if (grp.sel_release) begin
            lock_q <= 1'b0;  // group drained, move on
            ptr_q  <= en_idx;
         end else begin
            lock_q     <= 1'b1;
            lock_grp_q <= en_idx;
         end
      end
   end

endmodule

// File: rtl/pixel_groups.sv
`timescale 1ns/100ps
`include "readout_params.svh"

module pixel_groups (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] req_i,
   group_if.grp                                grp,
   output logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] gnt_out_o
);

   localparam int GPR = `PIX_COLS / `GRP_COLS;  // groups per array row

   logic [`NUM_GRP-1:0][`GRP_ROWS-1:0][`GRP_COLS-1:0] set_req;
   logic [`NUM_GRP-1:0][`GRP_ROWS-1:0][`GRP_COLS-1:0] gnt_grp;
   logic [`NUM_GRP-1:0][`GRP_AW-1:0]                  x_add;
   logic [`NUM_GRP-1:0][`GRP_AW-1:0]                  y_add;
   logic [`NUM_GRP-1:0]                               active;
   logic [`NUM_GRP-1:0]                               rel;
   logic [`NUM_GRP-1:0]                               grp_en_flat;
   logic [`NUM_GRP-1:0]                               grp_req_flat;

   assign grp_en_flat = grp.grp_en;   // group g sits at [g / GPR][g % GPR]
   assign grp.grp_req = grp_req_flat;

   // 2x2 window of group g inside the array
   always_comb begin
      for (int g = 0; g < `NUM_GRP; g++) begin
         for (int r = 0; r < `GRP_ROWS; r++) begin
            for (int c = 0; c < `GRP_COLS; c++) begin
               set_req[g][r][c] =
                  req_i[(g / GPR) * `GRP_ROWS + r][(g % GPR) * `GRP_COLS + c];
               gnt_out_o[(g / GPR) * `GRP_ROWS + r][(g % GPR) * `GRP_COLS + c] =
                  gnt_grp[g][r][c];
            end
         end
      end
   end

   for (genvar g = 0; g < `NUM_GRP; g++) begin : gen_grp
      pixel_level pixel_level_i (
         .clk_i         (clk_i),
         .rst_n_i       (rst_n_i),
         .req_i         (set_req[g]),
         .enable_i      (grp_en_flat[g]),
         .grp_enable_i  (grp.fire),
         .req_o         (grp_req_flat[g]),
         .gnt_o         (gnt_grp[g]),
         .x_add_o       (x_add[g]),
         .y_add_o       (y_add[g]),
         .active_o      (active[g]),
         .grp_release_o (rel[g])
      );
   end

   // only the enabled group reaches the arbiter
   always_comb begin
      grp.sel_x       = '0;
      grp.sel_y       = '0;
      grp.sel_active  = 1'b0;
      grp.sel_release = 1'b0;
      for (int g = 0; g < `NUM_GRP; g++) begin
         if (grp_en_flat[g]) begin
            grp.sel_x       = x_add[g];
            grp.sel_y       = y_add[g];
            grp.sel_active  = active[g];
            grp.sel_release = rel[g];
         end
      end
   end

endmodule

// File: rtl/pixel_level.sv
`timescale 1ns/100ps
`include "readout_params.svh"

module pixel_level (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic [`GRP_ROWS-1:0][`GRP_COLS-1:0] req_i,
   input  logic                                enable_i,
   input  logic                                grp_enable_i,
   output logic                                req_o,
   output logic [`GRP_ROWS-1:0][`GRP_COLS-1:0] gnt_o,
   output logic [`GRP_AW-1:0]                  x_add_o,
   output logic [`GRP_AW-1:0]                  y_add_o,
   output logic                                active_o,
   output logic                                grp_release_o
);

   localparam int GRP_PIX = `GRP_ROWS * `GRP_COLS;
   localparam int IDX_W   = 2 * `GRP_AW;

   logic [GRP_PIX-1:0] req_flat;  // index is row * cols + col
   logic [IDX_W-1:0]   ptr_q;
   logic [IDX_W-1:0]   win;
   logic [IDX_W-1:0]   cand;
   logic               found;
   logic               take;

   assign req_flat = req_i;

   // first pending pixel after the last one served
   always_comb begin
      win   = ptr_q;
      found = 1'b0;
      for (int i = 1; i <= GRP_PIX; i++) begin
         cand = ptr_q + IDX_W'(i);
         if (!found && req_flat[cand]) begin
            win   = cand;
            found = 1'b1;
         end
      end
   end

   assign req_o         = |req_flat;
   assign active_o      = enable_i & req_o;
   assign take          = active_o & grp_enable_i;
   assign gnt_o         = take ? (GRP_PIX'(1) << win) : '0;
   assign x_add_o       = win[`GRP_AW-1:0];
   assign y_add_o       = win[IDX_W-1:`GRP_AW];
   assign grp_release_o = ($countones(req_flat) == 1);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ptr_q <= '1;  // pixel 0 goes first
      end else if (take) begin
         ptr_q <= win;
      end
   end

endmodule

// File: rtl/grant_if.sv
`timescale 1ns/100ps
`include "readout_params.svh"

interface grant_if;
   logic               active;
   logic [`PIX_AW-1:0] x;       // global column
   logic [`PIX_AW-1:0] y;       // global row
   logic               fire;

   // arbiter side offers the winner
   modport arb (
      output active, x, y,
      input  fire
   );

   // controller side decides when to take it
   modport ctrl (
      input  active, x, y,
      output fire
   );

endinterface

// File: rtl/group_if.sv
`timescale 1ns/100ps
`include "readout_params.svh"

interface group_if;
   logic [`PIX_ROWS/`GRP_ROWS-1:0][`PIX_COLS/`GRP_COLS-1:0] grp_req;  // any pixel pending
   logic [`PIX_ROWS/`GRP_ROWS-1:0][`PIX_COLS/`GRP_COLS-1:0] grp_en;   // one-hot
   logic                fire;
   logic [`GRP_AW-1:0]  sel_x;
   logic [`GRP_AW-1:0]  sel_y;
   logic                sel_active;
   logic                sel_release;  // chosen pixel is the last one in its group

   modport grp (
      output grp_req, sel_x, sel_y, sel_active, sel_release,
      input  grp_en, fire
   );

   modport arb (
      input  grp_req, sel_x, sel_y, sel_active, sel_release,
      output grp_en, fire
   );
endinterface

// File: rtl/readout_pkg.sv
`include "readout_params.svh"

package readout_pkg;

   localparam logic EVT_KIND_PIX = 1'b0;
   localparam logic EVT_KIND_TS  = 1'b1;

   // pixel event view
   typedef struct packed {
      logic                 kind;
      logic [`PIX_AW-1:0]   x;       // column
      logic [`PIX_AW-1:0]   y;       // row
      logic [`TS_LOW_W-1:0] ts_low;
   } evt_pix_t;

   // timestamp marker view
   typedef struct packed {
      logic                  kind;
      logic [`TS_HIGH_W-1:0] ts_high;
   } evt_marker_t;

   // one output word, decoded by its kind bit
   typedef union packed {
      evt_pix_t    pix;
      evt_marker_t marker;
   } evt_word_u;

endpackage

// File: rtl/readout_params.svh
`ifndef READOUT_PARAMS_SVH
`define READOUT_PARAMS_SVH

// pixel array and group geometry
`define PIX_ROWS     8
`define PIX_COLS     8
`define GRP_ROWS     2
`define GRP_COLS     2
`define NUM_GRP      16
`define GRP_AW       1
`define PIX_AW       3

`define MAX_CREDITS  4
`define CREDIT_W     3

`define TS_LOW_W     9
`define TS_HIGH_W    15

`endif
